// ==== Bender.yml ====
package:
  name: serial_core

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/serial_pkg.sv
      - rtl/serial_state.sv
      - rtl/serial_decode.sv
      - rtl/serial_operand.sv
      - rtl/serial_alu_slice.sv
      - rtl/serial_rf_if.sv
      - rtl/serial_core.sv
  - target: simulation
    include_dirs:
      - rtl
    files:
      - sim/tb_clock.sv
      - sim/tb_serial_core.sv

// ==== rtl/serial_alu_slice.sv ====
module serial_alu_slice
   import serial_pkg::*;
(
   input  alu_op_e   i_op,
   input  lane_in_t  i_lane,
   input  logic      i_carry,
   output lane_out_t o_lane
);

   logic sum;
   logic carry;

   // Full adder bit
   assign sum   = i_lane.rs1 ^ i_lane.op_b ^ i_carry;
   assign carry = (i_lane.rs1 & i_lane.op_b) | (i_carry & (i_lane.rs1 ^ i_lane.op_b));

   always_comb begin
      o_lane.carry = carry;
      case (i_op)
         ALU_AND:      o_lane.res = i_lane.rs1 & i_lane.op_b;
         ALU_OR:       o_lane.res = i_lane.rs1 | i_lane.op_b;
         ALU_XOR:      o_lane.res = i_lane.rs1 ^ i_lane.op_b;
         ALU_PASS_IMM: o_lane.res = i_lane.imm;
         default:      o_lane.res = sum;
      endcase
   end

endmodule

// ==== rtl/serial_config.svh ====
`ifndef SERIAL_CONFIG_SVH
`define SERIAL_CONFIG_SVH

// Bits per cycle (1, 2 or 4)
`define SERIAL_W 1

// Run counter wide enough for 32/W cycles
`define SERIAL_CNT_W 5

`define SERIAL_RESET_PC 32'h0000_0000

`endif

// ==== rtl/serial_core.sv ====
`include "serial_config.svh"

module serial_core
   import serial_pkg::*;
(
   input  logic                 clk,
   input  logic                 i_reset,
   input  logic [31:0]          i_ibus_rdt,
   input  logic                 i_ibus_ack,
   output logic [31:0]          o_ibus_adr,
   output logic                 o_ibus_cyc,
   output logic                 o_rf_rreq,
   input  logic                 i_rf_ready,
   output logic [4:0]           o_rreg0,
   output logic [4:0]           o_rreg1,
   input  logic [`SERIAL_W-1:0] i_rdata0,
   input  logic [`SERIAL_W-1:0] i_rdata1,
   output logic [4:0]           o_wreg0,
   output logic                 o_wen0,
   output logic [`SERIAL_W-1:0] o_wdata0
);

   logic                      cnt_en;
   logic                      cnt0;
   logic                      cnt_done;
   dec_ctrl_t                 ctrl;
   logic [`SERIAL_W-1:0]      imm;
   lane_in_t  [`SERIAL_W-1:0] lanes_in;
   lane_out_t [`SERIAL_W-1:0] lanes_out;
   logic [`SERIAL_W-1:0]      lane_carry;
   logic                      carry_in;
   logic                      carry_out;

   serial_state u_state (
      .clk        (clk),
      .i_reset    (i_reset),
      .i_ibus_ack (i_ibus_ack),
      .i_rf_ready (i_rf_ready),
      .o_ibus_cyc (o_ibus_cyc),
      .o_ibus_adr (o_ibus_adr),
      .o_rf_rreq  (o_rf_rreq),
      .o_cnt_en   (cnt_en),
      .o_cnt0     (cnt0),
      .o_cnt_done (cnt_done)
   );

   serial_decode u_decode (
      .clk        (clk),
      .i_ibus_ack (i_ibus_ack),
      .i_ibus_rdt (i_ibus_rdt),
      .i_cnt_en   (cnt_en),
      .o_ctrl     (ctrl),
      .o_imm      (imm)
   );

   serial_operand u_operand (
      .clk         (clk),
      .i_ctrl      (ctrl),
      .i_cnt_en    (cnt_en),
      .i_cnt0      (cnt0),
      .i_rs1       (i_rdata0),
      .i_rs2       (i_rdata1),
      .i_imm       (imm),
      .i_carry_out (carry_out),
      .o_lanes     (lanes_in),
      .o_carry_in  (carry_in)
   );

   // Carry ripples up through the lanes within one cycle
   for (genvar i = 0; i < `SERIAL_W; i++) begin : g_lane
      if (i == 0) begin : g_first
         assign lane_carry[i] = carry_in;
      end else begin : g_chain
         assign lane_carry[i] = lanes_out[i-1].carry;
      end

      serial_alu_slice u_slice (
         .i_op    (ctrl.alu_op),
         .i_lane  (lanes_in[i]),
         .i_carry (lane_carry[i]),
         .o_lane  (lanes_out[i])
      );
   end

   serial_rf_if u_rf_if (
      .i_ctrl      (ctrl),
      .i_cnt_en    (cnt_en),
      .i_lanes     (lanes_out),
      .o_rreg0     (o_rreg0),
      .o_rreg1     (o_rreg1),
      .o_wreg0     (o_wreg0),
      .o_wen0      (o_wen0),
      .o_wdata0    (o_wdata0),
      .o_carry_out (carry_out)
   );

   // Writes start with the first run cycle and not partway through
   a_wen_in_run: assert property (
      @(posedge clk) disable iff (i_reset) $rose(o_wen0) |-> cnt0
   );

   // Back to fetch at the next word address right after the last run cycle
   a_fetch_after_run: assert property (
      @(posedge clk) disable iff (i_reset)
      cnt_done |=> o_ibus_cyc && (o_ibus_adr == $past(o_ibus_adr) + 32'd4)
   );

endmodule

// ==== rtl/serial_decode.sv ====
`include "serial_config.svh"

module serial_decode
   import serial_pkg::*;
(
   input  logic                 clk,
   input  logic                 i_ibus_ack,
   input  logic [31:0]          i_ibus_rdt,
   input  logic                 i_cnt_en,
   output dec_ctrl_t            o_ctrl,
   output logic [`SERIAL_W-1:0] o_imm
);

   typedef enum logic [6:0] {
      OPC_OP_IMM = 7'b0010011,
      OPC_OP     = 7'b0110011,
      OPC_LUI    = 7'b0110111
   } rv_opcode_e;

   logic [6:0]  opcode;
   logic [2:0]  funct3;
   logic [6:0]  funct7;
   logic        legal;
   logic        imm_sel;
   alu_op_e     op;
   dec_ctrl_t   ctrl_next;
   logic [31:0] imm_next;
   logic [31:0] imm_r;

   assign opcode = i_ibus_rdt[6:0];
   assign funct3 = i_ibus_rdt[14:12];
   assign funct7 = i_ibus_rdt[31:25];

   always_comb begin
      legal   = 1'b0;
      imm_sel = 1'b0;
      op      = ALU_ADD;
      case (opcode)
         OPC_OP: begin
            case (funct3)
               3'b000: begin
                  legal = (funct7 == 7'b0000000) || (funct7 == 7'b0100000);
                  op    = funct7[5] ? ALU_SUB : ALU_ADD;
               end
               3'b100: begin
                  legal = (funct7 == 7'b0000000);
                  op    = ALU_XOR;
               end
               3'b110: begin
                  legal = (funct7 == 7'b0000000);
                  op    = ALU_OR;
               end
               3'b111: begin
                  legal = (funct7 == 7'b0000000);
                  op    = ALU_AND;
               end
               default: legal = 1'b0;
            endcase
         end
         OPC_OP_IMM: begin
            imm_sel = 1'b1;
            legal   = (funct3 == 3'b000) || (funct3 == 3'b100) ||
                      (funct3 == 3'b110) || (funct3 == 3'b111);
            case (funct3)
               3'b100:  op = ALU_XOR;
               3'b110:  op = ALU_OR;
               3'b111:  op = ALU_AND;
               default: op = ALU_ADD;
            endcase
         end
         OPC_LUI: begin
            legal   = 1'b1;
            imm_sel = 1'b1;
            op      = ALU_PASS_IMM;
         end
         default: legal = 1'b0;
      endcase
   end

   always_comb begin
      ctrl_next.alu_op  = op;
      ctrl_next.imm_sel = imm_sel;
      // Unknown encodings still run without a write
      ctrl_next.wen     = legal && (i_ibus_rdt[11:7] != 5'd0);
      ctrl_next.rd      = i_ibus_rdt[11:7];
      ctrl_next.rs1     = i_ibus_rdt[19:15];
      ctrl_next.rs2     = i_ibus_rdt[24:20];
   end

   assign imm_next = (opcode == OPC_LUI) ? {i_ibus_rdt[31:12], 12'd0}
                                         : {{20{i_ibus_rdt[31]}}, i_ibus_rdt[31:20]};

   always_ff @(posedge clk) begin
      if (i_ibus_ack) begin
         o_ctrl <= ctrl_next;
         imm_r  <= imm_next;
      end else if (i_cnt_en) begin
         imm_r <= imm_r >> `SERIAL_W;
      end
   end

   // LSBs first
   assign o_imm = imm_r[`SERIAL_W-1:0];

endmodule

// ==== rtl/serial_operand.sv ====
`include "serial_config.svh"

module serial_operand
   import serial_pkg::*;
(
   input  logic                     clk,
   input  dec_ctrl_t                i_ctrl,
   input  logic                     i_cnt_en,
   input  logic                     i_cnt0,
   input  logic [`SERIAL_W-1:0]     i_rs1,
   input  logic [`SERIAL_W-1:0]     i_rs2,
   input  logic [`SERIAL_W-1:0]     i_imm,
   input  logic                     i_carry_out,
   output lane_in_t [`SERIAL_W-1:0] o_lanes,
   output logic                     o_carry_in
);

   logic sub;
   logic carry_r;

   assign sub = (i_ctrl.alu_op == ALU_SUB);

   always_comb begin
      for (int i = 0; i < `SERIAL_W; i++) begin
         o_lanes[i].rs1  = i_rs1[i];
         // Subtract inverts b here and takes the +1 from the carry-in
         o_lanes[i].op_b = (i_ctrl.imm_sel ? i_imm[i] : i_rs2[i]) ^ sub;
         o_lanes[i].imm  = i_imm[i];
      end
   end

   // Top lane carry joins this cycle to the next
   always_ff @(posedge clk) begin
      if (i_cnt_en) begin
         carry_r <= i_carry_out;
      end
   end

   assign o_carry_in = i_cnt0 ? sub : carry_r;

endmodule

// ==== rtl/serial_pkg.sv ====
package serial_pkg;

   typedef enum logic [2:0] {
      ALU_ADD      = 3'd0,
      ALU_SUB      = 3'd1,
      ALU_AND      = 3'd2,
      ALU_OR       = 3'd3,
      ALU_XOR      = 3'd4,
      ALU_PASS_IMM = 3'd5
   } alu_op_e;

   typedef enum logic [1:0] {
      ST_FETCH      = 2'd0,
      ST_REQUEST    = 2'd1,
      ST_WAIT_READY = 2'd2,
      ST_RUN        = 2'd3
   } state_e;

   // Decoded instruction held from one ack until the next
   typedef struct packed {
      alu_op_e    alu_op;
      logic       imm_sel;
      logic       wen;
      logic [4:0] rd;
      logic [4:0] rs1;
      logic [4:0] rs2;
   } dec_ctrl_t;

   // Operand bits for one lane with op_b already inverted for SUB
   typedef struct packed {
      logic rs1;
      logic op_b;
      logic imm;
   } lane_in_t;

   typedef struct packed {
      logic res;
      logic carry;
   } lane_out_t;

   typedef struct packed {
      logic       wen;
      logic [4:0] rd;
   } rf_wr_t;

endpackage

// ==== rtl/serial_rf_if.sv ====
`include "serial_config.svh"

module serial_rf_if
   import serial_pkg::*;
(
   input  dec_ctrl_t                 i_ctrl,
   input  logic                      i_cnt_en,
   input  lane_out_t [`SERIAL_W-1:0] i_lanes,
   output logic [4:0]                o_rreg0,
   output logic [4:0]                o_rreg1,
   output logic [4:0]                o_wreg0,
   output logic                      o_wen0,
   output logic [`SERIAL_W-1:0]      o_wdata0,
   output logic                      o_carry_out
);

   rf_wr_t wr;

   always_comb begin
      wr.wen = i_cnt_en && i_ctrl.wen;
      wr.rd  = i_ctrl.rd;
   end

   assign o_wen0  = wr.wen;
   assign o_wreg0 = wr.rd;

   // Read addresses stay put from rreq through the run
   assign o_rreg0 = i_ctrl.rs1;
   assign o_rreg1 = i_ctrl.rs2;

   always_comb begin
      for (int i = 0; i < `SERIAL_W; i++) begin
         o_wdata0[i] = i_lanes[i].res;
      end
   end

   assign o_carry_out = i_lanes[`SERIAL_W-1].carry;

endmodule

// ==== rtl/serial_state.sv ====
`include "serial_config.svh"

module serial_state
   import serial_pkg::*;
(
   input  logic        clk,
   input  logic        i_reset,
   input  logic        i_ibus_ack,
   input  logic        i_rf_ready,
   output logic        o_ibus_cyc,
   output logic [31:0] o_ibus_adr,
   output logic        o_rf_rreq,
   output logic        o_cnt_en,
   output logic        o_cnt0,
   output logic        o_cnt_done
);

   localparam int unsigned RUN_LEN = 32 / `SERIAL_W;
   localparam logic [`SERIAL_CNT_W-1:0] CNT_LAST = RUN_LEN[`SERIAL_CNT_W-1:0] - 1'b1;

   state_e                   state;
   logic [`SERIAL_CNT_W-1:0] cnt;
   logic [31:0]              pc;

   assign o_ibus_cyc = (state == ST_FETCH);
   assign o_rf_rreq  = (state == ST_REQUEST);
   assign o_cnt_en   = (state == ST_RUN);
   assign o_cnt0     = o_cnt_en && (cnt == '0);
   assign o_cnt_done = o_cnt_en && (cnt == CNT_LAST);
   assign o_ibus_adr = pc;

   always_ff @(posedge clk) begin
      if (i_reset) begin
         state <= ST_FETCH;
      end else begin
         case (state)
            ST_FETCH: begin
               if (i_ibus_ack) begin
                  state <= ST_REQUEST;
               end
            end
            ST_REQUEST: state <= ST_WAIT_READY;
            ST_WAIT_READY: begin
               // No limit on how long the register file takes
               if (i_rf_ready) begin
                  state <= ST_RUN;
               end
            end
            ST_RUN: begin
               if (o_cnt_done) begin
                  state <= ST_FETCH;
               end
            end
            default: state <= ST_FETCH;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (i_reset) begin
         cnt <= '0;
      end else if (o_cnt_done) begin
         cnt <= '0;
      end else if (o_cnt_en) begin
         cnt <= cnt + 1'b1;
      end
   end

   // Next sequential instruction once the run completes
   always_ff @(posedge clk) begin
      if (i_reset) begin
         pc <= `SERIAL_RESET_PC;
      end else if (o_cnt_done) begin
         pc <= pc + 32'd4;
      end
   end

   a_no_fetch_in_run: assert property (
      @(posedge clk) disable iff (i_reset) !(o_ibus_cyc && o_cnt_en)
   );

   a_rreq_single: assert property (
      @(posedge clk) disable iff (i_reset) o_rf_rreq |=> !o_rf_rreq
   );

endmodule

// ==== serial_core.f ====
+incdir+rtl
rtl/serial_pkg.sv
rtl/serial_state.sv
rtl/serial_decode.sv
rtl/serial_operand.sv
rtl/serial_alu_slice.sv
rtl/serial_rf_if.sv
rtl/serial_core.sv
sim/tb_clock.sv
sim/tb_serial_core.sv

// ==== sim/tb_clock.sv ====
module tb_clock (
   output logic o_clk
);
   timeunit 1ns;
   timeprecision 1ps;

   localparam int HALF_PERIOD_NS = 2;

   initial begin
      o_clk = 1'b0;
      forever #HALF_PERIOD_NS o_clk = ~o_clk;
   end

endmodule

// ==== sim/tb_serial_core.sv ====
`include "serial_config.svh"

module tb_serial_core;
   timeunit 1ns;
   timeprecision 1ps;

   localparam int CLK_PERIOD_NS    = 4;
   localparam int RUN_LEN          = 32 / `SERIAL_W;
   localparam int NUM_INSTR        = 42;
   localparam int CYCLES_PER_INSTR = 200;

   localparam logic [6:0] OPC_OP     = 7'b0110011;
   localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
   localparam logic [6:0] OPC_LUI    = 7'b0110111;
   localparam logic [6:0] OPC_LOAD   = 7'b0000011;
   localparam logic [2:0] F3_ADD     = 3'b000;
   localparam logic [2:0] F3_SLL     = 3'b001;
   localparam logic [2:0] F3_SLT     = 3'b010;
   localparam logic [2:0] F3_XOR     = 3'b100;
   localparam logic [2:0] F3_OR      = 3'b110;
   localparam logic [2:0] F3_AND     = 3'b111;
   localparam logic [6:0] F7_BASE    = 7'b0000000;
   localparam logic [6:0] F7_SUB     = 7'b0100000;
   localparam logic [6:0] F7_MULDIV  = 7'b0000001;

   logic                 clk;
   logic                 i_reset;
   logic [31:0]          i_ibus_rdt;
   logic                 i_ibus_ack;
   logic [31:0]          o_ibus_adr;
   logic                 o_ibus_cyc;
   logic                 o_rf_rreq;
   logic                 i_rf_ready;
   logic [4:0]           o_rreg0;
   logic [4:0]           o_rreg1;
   logic [`SERIAL_W-1:0] i_rdata0;
   logic [`SERIAL_W-1:0] i_rdata1;
   logic [4:0]           o_wreg0;
   logic                 o_wen0;
   logic [`SERIAL_W-1:0] o_wdata0;

   logic [31:0] rf [32];
   logic [31:0] rng_state;
   logic [31:0] expected_pc;

   tb_clock u_clock (
      .o_clk (clk)
   );

   serial_core u_dut (
      .clk        (clk),
      .i_reset    (i_reset),
      .i_ibus_rdt (i_ibus_rdt),
      .i_ibus_ack (i_ibus_ack),
      .o_ibus_adr (o_ibus_adr),
      .o_ibus_cyc (o_ibus_cyc),
      .o_rf_rreq  (o_rf_rreq),
      .i_rf_ready (i_rf_ready),
      .o_rreg0    (o_rreg0),
      .o_rreg1    (o_rreg1),
      .i_rdata0   (i_rdata0),
      .i_rdata1   (i_rdata1),
      .o_wreg0    (o_wreg0),
      .o_wen0     (o_wen0),
      .o_wdata0   (o_wdata0)
   );

   task automatic abort_run();
      $display("TESTS FAILED");
      $fatal(1, "Stopping at the first failure");
   endtask

   task automatic check_value(input string name, input logic [31:0] actual,
                              input logic [31:0] expected);
      assert (actual === expected) else begin
         $display("[ERROR] t=%0t %s expected 0x%08h actual 0x%08h",
                  $time, name, expected, actual);
         abort_run();
      end
   endtask

   function automatic logic [31:0] xorshift32(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   function automatic logic [31:0] next_random();
      rng_state = xorshift32(rng_state);
      return rng_state;
   endfunction

   function automatic logic [31:0] sign_extend_12(input logic [11:0] imm);
      return {{20{imm[11]}}, imm};
   endfunction

   function automatic logic [31:0] r_type_word(input logic [6:0] f7, input logic [4:0] rs2,
                                               input logic [4:0] rs1, input logic [2:0] f3,
                                               input logic [4:0] rd);
      return {f7, rs2, rs1, f3, rd, OPC_OP};
   endfunction

   function automatic logic [31:0] i_type_word(input logic [11:0] imm, input logic [4:0] rs1,
                                               input logic [2:0] f3, input logic [4:0] rd);
      return {imm, rs1, f3, rd, OPC_OP_IMM};
   endfunction

   function automatic logic [31:0] lui_word(input logic [19:0] imm, input logic [4:0] rd);
      return {imm, rd, OPC_LUI};
   endfunction

   // One full instruction through fetch, register read, serial run and writeback
   task automatic exec_instr(input logic [31:0] instr, input logic exp_wen,
                             input logic [31:0] exp_res);
      int unsigned fetch_wait;
      int unsigned ready_wait;
      logic [31:0] shadow;
      logic [31:0] op_a;
      logic [31:0] op_b;
      logic [31:0] r;
      r          = next_random();
      fetch_wait = r % 4;
      r          = next_random();
      ready_wait = 1 + (r % 5);
      shadow     = '0;
      check_value("o_ibus_cyc", o_ibus_cyc, 1'b1);
      check_value("o_ibus_adr", o_ibus_adr, expected_pc);
      repeat (fetch_wait) begin
         @(negedge clk);
         check_value("o_ibus_cyc", o_ibus_cyc, 1'b1);
         check_value("o_rf_rreq", o_rf_rreq, 1'b0);
         check_value("o_wen0", o_wen0, 1'b0);
      end
      i_ibus_ack = 1'b1;
      i_ibus_rdt = instr;
      @(negedge clk);
      i_ibus_ack = 1'b0;
      i_ibus_rdt = '0;
      check_value("o_rf_rreq", o_rf_rreq, 1'b1);
      check_value("o_ibus_cyc", o_ibus_cyc, 1'b0);
      check_value("o_rreg0", o_rreg0, instr[19:15]);
      check_value("o_rreg1", o_rreg1, instr[24:20]);
      // Register file needs at least one cycle
      repeat (ready_wait) begin
         @(negedge clk);
         check_value("o_rf_rreq", o_rf_rreq, 1'b0);
         check_value("o_wen0", o_wen0, 1'b0);
         check_value("o_ibus_cyc", o_ibus_cyc, 1'b0);
      end
      i_rf_ready = 1'b1;
      @(negedge clk);
      i_rf_ready = 1'b0;
      op_a = rf[o_rreg0];
      op_b = rf[o_rreg1];
      for (int k = 0; k < RUN_LEN; k++) begin
         i_rdata0 = op_a[k*`SERIAL_W +: `SERIAL_W];
         i_rdata1 = op_b[k*`SERIAL_W +: `SERIAL_W];
         #1;
         check_value("o_wen0", o_wen0, exp_wen);
         check_value("o_wreg0", o_wreg0, instr[11:7]);
         check_value("o_ibus_cyc", o_ibus_cyc, 1'b0);
         shadow[k*`SERIAL_W +: `SERIAL_W] = o_wdata0;
         @(negedge clk);
      end
      i_rdata0 = '0;
      i_rdata1 = '0;
      check_value("o_wen0", o_wen0, 1'b0);
      check_value("o_ibus_cyc", o_ibus_cyc, 1'b1);
      check_value("o_ibus_adr", o_ibus_adr, expected_pc + 32'd4);
      if (exp_wen) begin
         check_value("o_wdata0", shadow, exp_res);
         rf[instr[11:7]] = shadow;
      end
      expected_pc = expected_pc + 32'd4;
   endtask

   task automatic reset_values();
      repeat (8) @(negedge clk);
      i_reset = 1'b0;
      repeat (3) begin
         @(negedge clk);
         check_value("o_ibus_cyc", o_ibus_cyc, 1'b1);
         check_value("o_ibus_adr", o_ibus_adr, `SERIAL_RESET_PC);
         check_value("o_rf_rreq", o_rf_rreq, 1'b0);
         check_value("o_wen0", o_wen0, 1'b0);
      end
   endtask

   task automatic add_and_sub();
      logic [31:0] a;
      logic [31:0] b;
      for (int i = 0; i < 4; i++) begin
         a = next_random();
         b = next_random();
         // Carry through every bit
         if (i == 0) begin
            a = 32'hffff_ffff;
            b = 32'h0000_0001;
         end
         rf[1] = a;
         rf[2] = b;
         exec_instr(r_type_word(F7_BASE, 5'd2, 5'd1, F3_ADD, 5'd3), 1'b1, a + b);
         exec_instr(r_type_word(F7_SUB, 5'd2, 5'd1, F3_ADD, 5'd4), 1'b1, a - b);
      end
   endtask

   task automatic register_logic();
      logic [31:0] a;
      logic [31:0] b;
      for (int i = 0; i < 3; i++) begin
         a = next_random();
         b = next_random();
         rf[5] = a;
         rf[6] = b;
         exec_instr(r_type_word(F7_BASE, 5'd6, 5'd5, F3_AND, 5'd7), 1'b1, a & b);
         exec_instr(r_type_word(F7_BASE, 5'd6, 5'd5, F3_OR, 5'd8), 1'b1, a | b);
         exec_instr(r_type_word(F7_BASE, 5'd6, 5'd5, F3_XOR, 5'd9), 1'b1, a ^ b);
      end
   endtask

   task automatic immediate_forms();
      logic [11:0] imms [4];
      logic [31:0] a;
      logic [31:0] ext;
      logic [31:0] r;
      r       = next_random();
      imms[0] = 12'h7ff;
      imms[1] = 12'h800;
      imms[2] = 12'hfff;
      imms[3] = r[11:0];
      for (int i = 0; i < 4; i++) begin
         a     = next_random();
         ext   = sign_extend_12(imms[i]);
         rf[10] = a;
         exec_instr(i_type_word(imms[i], 5'd10, F3_ADD, 5'd11), 1'b1, a + ext);
         exec_instr(i_type_word(imms[i], 5'd10, F3_AND, 5'd12), 1'b1, a & ext);
         exec_instr(i_type_word(imms[i], 5'd10, F3_OR, 5'd13), 1'b1, a | ext);
         exec_instr(i_type_word(imms[i], 5'd10, F3_XOR, 5'd14), 1'b1, a ^ ext);
      end
      r = next_random();
      exec_instr(lui_word(r[31:12], 5'd15), 1'b1, {r[31:12], 12'h000});
      exec_instr(lui_word(20'hfffff, 5'd16), 1'b1, 32'hffff_f000);
   endtask

   // No write may leave the core for x0 or unknown encodings
   task automatic sequencing();
      rf[1] = next_random();
      rf[2] = next_random();
      exec_instr(r_type_word(F7_BASE, 5'd2, 5'd1, F3_ADD, 5'd0), 1'b0, '0);
      exec_instr(i_type_word(12'h123, 5'd1, F3_ADD, 5'd0), 1'b0, '0);
      exec_instr(lui_word(20'habcde, 5'd0), 1'b0, '0);
      exec_instr(r_type_word(F7_BASE, 5'd2, 5'd1, F3_SLL, 5'd20), 1'b0, '0);
      exec_instr({12'h004, 5'd1, F3_SLT, 5'd21, OPC_LOAD}, 1'b0, '0);
      exec_instr(r_type_word(F7_MULDIV, 5'd2, 5'd1, F3_ADD, 5'd22), 1'b0, '0);
      exec_instr(i_type_word(12'h010, 5'd1, F3_SLT, 5'd23), 1'b0, '0);
   endtask

   initial begin
      i_reset     = 1'b1;
      i_ibus_rdt  = '0;
      i_ibus_ack  = 1'b0;
      i_rf_ready  = 1'b0;
      i_rdata0    = '0;
      i_rdata1    = '0;
      rng_state   = 32'hef2b4c12;
      expected_pc = `SERIAL_RESET_PC;
      rf[0] = '0;
      for (int i = 1; i < 32; i++) begin
         rf[i] = {4{3'b101, i[4:0]}};
      end
      reset_values();
      add_and_sub();
      register_logic();
      immediate_forms();
      sequencing();
      $display("TESTS PASSED");
      $finish;
   end

   initial begin
      #(CLK_PERIOD_NS * (CYCLES_PER_INSTR * NUM_INSTR + 11));
      $display("Timeout: the core did not finish all instructions in the allowed time");
      abort_run();
   end

endmodule
